//--- list.f
+incdir+include
hdl/fc_stream_pkg.sv
hdl/fc_ctrl_pkg.sv
hdl/chdr_hdr_parser.sv
hdl/fc_ack_trigger.sv
hdl/fc_pkt_framer.sv
hdl/fc_responder_top.sv
sim/tb_fc_responder.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the flow control responder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_fc_responder -o tb_fc_responder > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_fc_responder > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- sim/tb_fc_responder.sv
// ================================================
// Testbench for the flow control responder
// Clock, reset, packet stimulus, reference queues,
// concurrent checks and a watchdog
// ================================================
`timescale 1ns/1ps
`include "fc_config.svh"

module tb_fc_responder
  import fc_stream_pkg::*, fc_ctrl_pkg::*;
();

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_PKTS       = 12;
  // Budget per data packet and its ack under random back-pressure
  localparam int TIMEOUT_CYCLES = NUM_PKTS * 1600 + 800;

  logic         clk;
  logic         rst;
  set_bus_t     set_bus;
  stream_beat_t in_beat;
  logic         in_valid;
  logic         in_ready;
  stream_beat_t out_beat;
  logic         out_valid;
  logic         out_ready;
  stream_beat_t fc_beat;
  logic         fc_valid;
  logic         fc_ready;

  // Reference model
  stream_beat_t pass_q[$];
  stream_beat_t fc_q[$];
  stream_beat_t exp_out;
  stream_beat_t exp_fc;
  int           pass_cnt;
  int           fc_exp_cnt;
  int           fc_idx;
  logic [19:0]  ext_hi;
  logic [11:0]  last_low;
  logic [11:0]  fc_seq_exp;
  int           pkts_per_ack;
  bit           cyc_on;
  int           since_ack;
  integer       seed = 32'h7c87_122d;

  fc_responder_top dut_i (
    .clk         (clk),
    .i_rst       (rst),
    .i_set       (set_bus),
    .i_in        (in_beat),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .o_out       (out_beat),
    .o_out_valid (out_valid),
    .i_out_ready (out_ready),
    .o_fc        (fc_beat),
    .o_fc_valid  (fc_valid),
    .i_fc_ready  (fc_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [64:0] exp,
                                 input logic [64:0] act);
    $display("FAIL %s: expected %h, actual %h", name, exp, act);
    stop_run();
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    stop_run();
  endtask

  function automatic string fc_beat_name(input int idx);
    case (idx)
      0:       return "fc header";
      1:       return "fc timestamp";
      default: return "fc payload";
    endcase
  endfunction

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    set_bus = '{stb: 1'b1, addr: addr, data: data};
    @(posedge clk);
    #1;
    set_bus.stb = 1'b0;
  endtask

  // Hold the beat until the edge where valid and ready meet
  task automatic drive_beat(input stream_beat_t beat);
    in_beat  = beat;
    in_valid = 1'b1;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic send_packet(input logic [11:0] seq, input logic [15:0] src_sid,
                             input logic [15:0] dst_sid);
    chdr_hdr_t   hdr;
    chdr_hdr_t   fc_hdr;
    logic [63:0] ts;
    logic [31:0] ext;
    bit          ack_due;
    ts  = 64'h0000_0123_0000_0000 + 64'(seq) * 64'd977;
    hdr = '{pkt_type: DATA, has_time: 1'b1, eob: 1'b0, seqnum: seq,
            length: 16'd24, src_sid: src_sid, dst_sid: dst_sid};
    drive_beat('{tdata: hdr, tlast: 1'b0});
    drive_beat('{tdata: ts, tlast: 1'b0});
    drive_beat('{tdata: ~ts, tlast: 1'b1});
    // Upper 20 bits advance when the previous low part was FFF
    if (last_low == 12'hFFF) ext_hi = ext_hi + 20'd1;
    last_low = seq;
    ext      = {ext_hi, seq};
    ack_due  = 1'b0;
    if (pkts_per_ack != 0) begin
      since_ack++;
      if (since_ack == pkts_per_ack) begin
        ack_due   = 1'b1;
        since_ack = 0;
      end
    end else if (cyc_on) begin
      ack_due = 1'b1;
    end
    if (ack_due) begin
      fc_hdr = '{pkt_type: FLOW_CTRL, has_time: 1'b1, eob: 1'b0, seqnum: fc_seq_exp,
                 length: 16'd24, src_sid: dst_sid, dst_sid: src_sid};
      fc_q.push_back('{tdata: fc_hdr, tlast: 1'b0});
      fc_q.push_back('{tdata: ts, tlast: 1'b0});
      fc_q.push_back('{tdata: {32'h0, ext}, tlast: 1'b1});
      fc_seq_exp = fc_seq_exp + 12'd1;
    end
    // Next packet waits until this one and its ack have left
    do begin
      @(posedge clk);
      #1;
    end while (pass_cnt != 0 || fc_exp_cnt != 0);
  endtask

  always @(posedge clk) begin
    if (in_valid && in_ready) pass_q.push_back(in_beat);
    if (out_valid && out_ready) void'(pass_q.pop_front());
    if (fc_valid && fc_ready) begin
      void'(fc_q.pop_front());
      fc_idx = fc_beat.tlast ? 0 : fc_idx + 1;
    end
    pass_cnt   = pass_q.size();
    fc_exp_cnt = fc_q.size();
    exp_out    = (pass_cnt != 0) ? pass_q[0] : '0;
    exp_fc     = (fc_exp_cnt != 0) ? fc_q[0] : '0;
  end

  a_reset_idle: assert property (@(posedge clk) $past(rst) |-> !out_valid && !fc_valid)
    else report_error("a stream valid was high right after reset");

  a_pass_through: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> out_beat == exp_out)
    else report_mismatch("pass-through", $sampled(exp_out), $sampled(out_beat));

  // An empty or draining stage must take the next beat
  a_in_ready: assert property (@(posedge clk) disable iff (rst)
    (!out_valid || out_ready) |-> in_ready)
    else report_error("input ready was low while the pass-through stage had room");

  a_fc_expected: assert property (@(posedge clk) disable iff (rst)
    fc_valid |-> fc_exp_cnt != 0)
    else report_error("an fc packet appeared with no ack due");

  a_fc_beat: assert property (@(posedge clk) disable iff (rst)
    fc_valid && fc_ready |-> fc_beat == exp_fc)
    else report_mismatch(fc_beat_name($sampled(fc_idx)), $sampled(exp_fc),
                         $sampled(fc_beat));

  a_fc_hold: assert property (@(posedge clk) disable iff (rst)
    fc_valid && !fc_ready |=> fc_valid && $stable(fc_beat))
    else report_error("an fc beat changed before it was taken");

  a_fc_len: assert property (@(posedge clk) disable iff (rst)
    fc_valid && fc_ready && fc_beat.tlast |-> fc_idx == 2)
    else report_mismatch("fc beat count", 65'd3, 65'($sampled(fc_idx)) + 65'd1);

  // Random back-pressure on both outputs
  initial begin
    forever begin
      @(posedge clk);
      #1;
      out_ready = ($random(seed) & 3) != 0;
      fc_ready  = ($random(seed) & 1) != 0;
    end
  end

  initial begin
    int i;
    rst          = 1'b1;
    set_bus      = '0;
    in_beat      = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    fc_ready     = 1'b0;
    pass_cnt     = 0;
    fc_exp_cnt   = 0;
    fc_idx       = 0;
    exp_out      = '0;
    exp_fc       = '0;
    ext_hi       = '0;
    last_low     = '0;
    fc_seq_exp   = '0;
    pkts_per_ack = 0;
    cyc_on       = 1'b0;
    since_ack    = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    // One ack per two packets
    write_reg(`SR_PKTS_PER_ACK, 32'h8000_0002);
    pkts_per_ack = 2;
    for (i = 0; i < 4; i++) begin
      send_packet(12'd10 + 12'(i), 16'h0100 + 16'(i), 16'h0200 + 16'(i));
    end
    // One ack per packet across the 12-bit seqnum wrap
    write_reg(`SR_PKTS_PER_ACK, 32'h8000_0001);
    pkts_per_ack = 1;
    since_ack    = 0;
    send_packet(12'hFFE, 16'h0311, 16'h0422);
    send_packet(12'hFFF, 16'h0312, 16'h0423);
    send_packet(12'h000, 16'h0313, 16'h0424);
    send_packet(12'h001, 16'h0314, 16'h0425);
    // Cycle acks only
    write_reg(`SR_PKTS_PER_ACK, 32'h0);
    pkts_per_ack = 0;
    write_reg(`SR_CYCS_PER_ACK, 32'h8000_0008);
    cyc_on = 1'b1;
    send_packet(12'h002, 16'h0501, 16'h0602);
    send_packet(12'h003, 16'h0503, 16'h0604);
    // Both enables off
    write_reg(`SR_CYCS_PER_ACK, 32'h0);
    cyc_on = 1'b0;
    send_packet(12'h004, 16'h0701, 16'h0802);
    send_packet(12'h005, 16'h0703, 16'h0804);
    repeat (50) @(posedge clk);
    #1;
    if (pass_cnt != 0 || fc_exp_cnt != 0) begin
      report_error("expected beats still pending at the end of the run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    report_error("watchdog timeout, the test sequence did not complete");
  end

endmodule

//--- hdl/fc_responder_top.sv
// ================================================
// Flow control responder top level
// Header parser, ack trigger and packet framer
// ================================================
`timescale 1ns/1ps

module fc_responder_top
  import fc_stream_pkg::*, fc_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         i_rst,
  input  set_bus_t     i_set,
  input  stream_beat_t i_in,
  input  logic         i_in_valid,
  output logic         o_in_ready,
  output stream_beat_t o_out,
  output logic         o_out_valid,
  input  logic         i_out_ready,
  output stream_beat_t o_fc,
  output logic         o_fc_valid,
  input  logic         i_fc_ready
);

  hdr_info_t hdr_info;
  ack_req_t  ack_req;
  logic      ack_valid;
  logic      ack_ready;
  logic      consumed;

  // Last beat of a packet leaving the pass-through port
  assign consumed = o_out_valid && i_out_ready && o_out.tlast;

  chdr_hdr_parser parser_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_in        (i_in),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out       (o_out),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_hdr       (hdr_info)
  );

  fc_ack_trigger trigger_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_set       (i_set),
    .i_hdr       (hdr_info),
    .i_consumed  (consumed),
    .o_ack       (ack_req),
    .o_ack_valid (ack_valid),
    .i_ack_ready (ack_ready)
  );

  fc_pkt_framer framer_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_ack       (ack_req),
    .i_ack_valid (ack_valid),
    .o_ack_ready (ack_ready),
    .o_fc        (o_fc),
    .o_fc_valid  (o_fc_valid),
    .i_fc_ready  (i_fc_ready)
  );

endmodule

//--- hdl/fc_pkt_framer.sv
// ================================================
// Flow control packet framer
// Header, optional timestamp, then seqnum payload
// ================================================
`timescale 1ns/1ps
`include "fc_config.svh"

module fc_pkt_framer
  import fc_stream_pkg::*, fc_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         i_rst,
  input  ack_req_t     i_ack,
  input  logic         i_ack_valid,
  output logic         o_ack_ready,
  output stream_beat_t o_fc,
  output logic         o_fc_valid,
  input  logic         i_fc_ready
);

  // Length in bytes, 8 per beat
  localparam logic [15:0] FC_LEN = (`FC_USE_TIME != 0) ? 16'd24 : 16'd16;

  framer_state_e state;
  ack_req_t      ack_q;
  logic [11:0]   fc_seq;
  chdr_hdr_t     fc_hdr;

  assign o_ack_ready = (state == IDLE);
  assign o_fc_valid  = (state != IDLE);

  assign fc_hdr = '{
    pkt_type: FLOW_CTRL,
    has_time: 1'(`FC_USE_TIME),
    eob:      1'b0,
    seqnum:   fc_seq,
    length:   FC_LEN,
    src_sid:  ack_q.src_sid,
    dst_sid:  ack_q.dst_sid
  };

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state  <= IDLE;
      fc_seq <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (i_ack_valid) begin
            state <= HDR;
          end
        end
        HDR: begin
          if (i_fc_ready) begin
            state <= (`FC_USE_TIME != 0) ? TIME : PAYLOAD;
          end
        end
        TIME: begin
          if (i_fc_ready) begin
            state <= PAYLOAD;
          end
        end
        PAYLOAD: begin
          if (i_fc_ready) begin
            state  <= IDLE;
            fc_seq <= fc_seq + 12'd1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // One ack held while the packet goes out
  always_ff @(posedge clk) begin
    if (o_ack_ready && i_ack_valid) begin
      ack_q <= i_ack;
    end
  end

  always_comb begin
    o_fc = '0;
    case (state)
      HDR:  o_fc.tdata = fc_hdr;
      TIME: o_fc.tdata = ack_q.vita_time;
      PAYLOAD: begin
        o_fc.tdata = {32'h0, ack_q.seqnum_ext};
        o_fc.tlast = 1'b1;
      end
      default: o_fc = '0;
    endcase
  end

  a_fc_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_fc_valid && !i_fc_ready |=> o_fc_valid && $stable(o_fc));

endmodule

//--- hdl/fc_ack_trigger.sv
// ================================================
// Settings registers, seqnum extension, ack
// counters and the flow control ack request
// ================================================
`timescale 1ns/1ps
`include "fc_config.svh"

module fc_ack_trigger
  import fc_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst,
  input  set_bus_t  i_set,
  input  hdr_info_t i_hdr,
  input  logic      i_consumed,
  output ack_req_t  o_ack,
  output logic      o_ack_valid,
  input  logic      i_ack_ready
);

  logic                cyc_en;
  logic [`FC_CYC_W-1:0] cyc_limit;
  logic                pkt_en;
  logic [`FC_PKT_W-1:0] pkt_limit;
  logic [31:0]         seqnum_int;
  logic [`FC_CYC_W:0]   cycle_count;
  logic [`FC_PKT_W:0]   packet_count;
  logic                cyc_hit;
  logic                pkt_hit;
  logic                slot_free;
  logic                fire;

  // Settings: bit 31 is the enable, count in the low bits
  always_ff @(posedge clk) begin
    if (i_rst) begin
      cyc_en    <= 1'b0;
      cyc_limit <= '0;
      pkt_en    <= 1'b0;
      pkt_limit <= '0;
    end else if (i_set.stb) begin
      if (i_set.addr == `SR_CYCS_PER_ACK) begin
        cyc_en    <= i_set.data[31];
        cyc_limit <= i_set.data[`FC_CYC_W-1:0];
      end
      if (i_set.addr == `SR_PKTS_PER_ACK) begin
        pkt_en    <= i_set.data[31];
        pkt_limit <= i_set.data[`FC_PKT_W-1:0];
      end
    end
  end

  // Carry into the upper 20 bits when the 12-bit seqnum wraps
  always_ff @(posedge clk) begin
    if (i_rst) begin
      seqnum_int <= '0;
    end else if (i_hdr.hdr_stb) begin
      seqnum_int[11:0] <= i_hdr.seqnum;
      if (seqnum_int[11:0] == 12'hFFF) begin
        seqnum_int[31:12] <= seqnum_int[31:12] + 20'd1;
      end
    end
  end

  // Cycle counter only runs once started by a consumption
  assign cyc_hit = cyc_en && (cycle_count != '0) &&
                   (cycle_count >= {1'b0, cyc_limit});
  assign pkt_hit = pkt_en && (packet_count != '0) &&
                   (packet_count >= {1'b0, pkt_limit});

  // A pending ack blocks new triggers until the framer takes it
  assign slot_free = !o_ack_valid || i_ack_ready;
  assign fire      = (cyc_hit || pkt_hit) && slot_free;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      cycle_count  <= '0;
      packet_count <= '0;
      o_ack_valid  <= 1'b0;
    end else if (fire) begin
      cycle_count  <= '0;
      packet_count <= '0;
      o_ack_valid  <= 1'b1;
    end else begin
      if (o_ack_valid && i_ack_ready) begin
        o_ack_valid <= 1'b0;
      end
      if (cyc_en && (i_consumed || cycle_count != '0)) begin
        cycle_count <= cycle_count + 1'b1;
      end
      if (pkt_en && i_consumed) begin
        packet_count <= packet_count + 1'b1;
      end
    end
  end

  // Hold the seqnum, the next header moves seqnum_int on
  always_ff @(posedge clk) begin
    if (fire) begin
      o_ack <= '{
        seqnum_ext: seqnum_int,
        src_sid:    i_hdr.dst_sid,
        dst_sid:    i_hdr.src_sid,
        vita_time:  i_hdr.vita_time
      };
    end
  end

  a_ack_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_ack_valid && !i_ack_ready |=> o_ack_valid && $stable(o_ack));

endmodule

//--- hdl/chdr_hdr_parser.sv
// ================================================
// One-entry register stage for the CHDR stream
// Extracts header fields and the timestamp
// ================================================
`timescale 1ns/1ps

module chdr_hdr_parser
  import fc_stream_pkg::*, fc_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         i_rst,
  input  stream_beat_t i_in,
  input  logic         i_in_valid,
  output logic         o_in_ready,
  output stream_beat_t o_out,
  output logic         o_out_valid,
  input  logic         i_out_ready,
  output hdr_info_t    o_hdr
);

  logic        in_xfer;
  logic        sop;
  logic        time_next;
  logic        hdr_stb;
  logic [11:0] seqnum_q;
  logic [15:0] src_sid_q;
  logic [15:0] dst_sid_q;
  logic [63:0] vita_time_q;
  chdr_hdr_t   hdr_word;

  // Accept a new beat whenever the stage is empty or draining
  assign o_in_ready = !o_out_valid || i_out_ready;
  assign in_xfer    = i_in_valid && o_in_ready;
  assign hdr_word   = chdr_hdr_t'(i_in.tdata);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_out_valid <= 1'b0;
      sop         <= 1'b1;
      time_next   <= 1'b0;
      hdr_stb     <= 1'b0;
    end else begin
      hdr_stb <= in_xfer && sop;
      if (in_xfer) begin
        o_out_valid <= 1'b1;
        sop         <= i_in.tlast;
        // Timestamp follows the header when has_time is set
        time_next   <= sop && hdr_word.has_time && !i_in.tlast;
      end else if (i_out_ready) begin
        o_out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      o_out <= i_in;
      if (sop) begin
        seqnum_q  <= hdr_word.seqnum;
        src_sid_q <= hdr_word.src_sid;
        dst_sid_q <= hdr_word.dst_sid;
      end
      if (time_next) begin
        vita_time_q <= i_in.tdata;
      end
    end
  end

  assign o_hdr = '{
    hdr_stb:   hdr_stb,
    seqnum:    seqnum_q,
    src_sid:   src_sid_q,
    dst_sid:   dst_sid_q,
    vita_time: vita_time_q
  };

  // A held beat stays put until the consumer takes it
  a_out_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out));

endmodule

//--- hdl/fc_ctrl_pkg.sv
// ================================================
// Settings bus, header info, ack request structs
// and framer state enum
// ================================================
package fc_ctrl_pkg;

  // Strobed register writes, no handshake
  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  // Parser to trigger and framer
  typedef struct packed {
    logic        hdr_stb;
    logic [11:0] seqnum;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
    logic [63:0] vita_time;
  } hdr_info_t;

  // Trigger to framer, SIDs already swapped
  typedef struct packed {
    logic [31:0] seqnum_ext;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
    logic [63:0] vita_time;
  } ack_req_t;

  typedef enum logic [1:0] {
    IDLE,
    HDR,
    TIME,
    PAYLOAD
  } framer_state_e;

endpackage

//--- hdl/fc_stream_pkg.sv
// ================================================
// Stream beat struct, CHDR header word struct
// and CHDR packet type enum
// ================================================
`include "fc_config.svh"

package fc_stream_pkg;

  // One beat of the 64-bit packet stream
  typedef struct packed {
    logic [`FC_DATA_W-1:0] tdata;
    logic                  tlast;
  } stream_beat_t;

  // CHDR packet types, top two bits of the header
  typedef enum logic [1:0] {
    DATA      = 2'd0,
    FLOW_CTRL = 2'd1,
    CMD       = 2'd2,
    RESP      = 2'd3
  } chdr_pkt_type_e;

  // First word of every CHDR packet
  typedef struct packed {
    chdr_pkt_type_e pkt_type;
    logic           has_time;
    logic           eob;
    logic [11:0]    seqnum;
    logic [15:0]    length;
    logic [15:0]    src_sid;
    logic [15:0]    dst_sid;
  } chdr_hdr_t;

endpackage

//--- include/fc_config.svh
// ================================================
// Flow control responder configuration defines
// Settings addresses, timestamp option, widths
// ================================================
`ifndef FC_CONFIG_SVH
`define FC_CONFIG_SVH

// Settings bus register addresses
`define SR_CYCS_PER_ACK 8'd0
`define SR_PKTS_PER_ACK 8'd1

// Flow control packets carry a timestamp beat when set
`define FC_USE_TIME 1

// Field widths
`define FC_DATA_W 64
`define FC_CYC_W 24
`define FC_PKT_W 16

`endif
